// ==== hdl/rf_pkg.sv ====
package rf_pkg;

   // core data width and register count
   localparam int XLEN = 32;                 // integer data width
   localparam int NREG = 32;                 // number of architectural registers

   // typed vectors
   typedef logic [4:0]      rf_add;          // register address
   typedef logic [XLEN-1:0] rf_word;         // data word
   typedef logic [XLEN:0]   rf_entry;        // stored word, parity in bit 32
   typedef logic [5:0]      bit_sel;         // bit to flip, 0..32 (32 hits parity)

   // state of one repair slot
   typedef enum logic {
      RP_IDLE = 1'b0,                        // nothing to repair
      RP_PEND = 1'b1                         // repair waits for a free write port
   } repair_st;

   // even parity bit for a data word
   // stored {par_of(w), w} has an even number of ones, so the xor of
   // the full entry is zero when the copy is intact
   function automatic logic par_of(input rf_word w);
      return ^w;                             // xor reduction gives the even parity bit
   endfunction

endpackage

// ==== hdl/rf_bank.sv ====
`timescale 1ns/1ps

module rf_bank
   import rf_pkg::*;
(
   input  logic    s_clk_i,                  // clock
   input  logic    rst_i,                    // active high sync reset

   input  logic    we_i,                     // write enable
   input  rf_add   wa_i,                     // write address
   input  rf_word  d_i,                      // write data

   input  rf_add   ra1_i,                    // read port 1 address
   input  rf_add   ra2_i,                    // read port 2 address

   input  logic    inj_en_i,                 // fault injection strobe
   input  rf_add   inj_add_i,                // entry to corrupt
   input  bit_sel  inj_bit_i,                // bit of the entry to flip

   output rf_entry q1_o,                     // read port 1 entry with parity
   output rf_entry q2_o                      // read port 2 entry with parity
);

   rf_entry regs [NREG];                     // storage, one entry per register
   rf_entry flip_mask;                       // one-hot mask of the injected bit
   rf_entry wr_entry;                        // incoming word with its parity

   // shifting past bit 32 gives an empty mask so out of range bits do nothing
   assign flip_mask = rf_entry'(1) << inj_bit_i;
   assign wr_entry  = {par_of(d_i), d_i};   // parity generated on the way in

   // write port and injection share one process per entry
   always_ff @(posedge s_clk_i) begin
      for (int i = 0; i < NREG; i++) begin
         if (rst_i || i == 0) begin
            regs[i] <= '0;                   // zero word with zero parity
         end else if (we_i && wa_i == rf_add'(i)) begin
            regs[i] <= wr_entry;             // write wins over a flip
         end else if (inj_en_i && inj_add_i == rf_add'(i)) begin
            regs[i] <= regs[i] ^ flip_mask;  // upset one stored bit
         end
      end
   end

   // combinational reads without bypass of a same-cycle write
   assign q1_o = regs[ra1_i];
   assign q2_o = regs[ra2_i];

   // the write port owner never aims a write at x0
   a_no_x0_wr: assert property (
      @(posedge s_clk_i) disable iff (rst_i)
      !(we_i && wa_i == '0)
   );

endmodule

// ==== hdl/rf_acm.sv ====
`timescale 1ns/1ps

module rf_acm
   import rf_pkg::*;
(
   input  logic    s_clk_i,                  // clock
   input  logic    rst_i,                    // active high sync reset

   input  logic    wb_we_i,                  // writeback enable
   input  rf_add   wb_add_i,                 // writeback address
   input  rf_word  wb_val_i,                 // writeback data

   input  rf_add   rd1_add_i,                // read port 1 address
   input  rf_add   rd2_add_i,                // read port 2 address

   input  logic    acm_en_i,                 // allow automatic repair

   input  rf_entry b0_q1_i,                  // copy 0 on port 1
   input  rf_entry b0_q2_i,                  // copy 0 on port 2
   input  rf_entry b1_q1_i,                  // copy 1 on port 1
   input  rf_entry b1_q2_i,                  // copy 1 on port 2

   output rf_word  rd1_val_o,                // corrected value on port 1
   output rf_word  rd2_val_o,                // corrected value on port 2
   output logic    corr_o,                   // a mismatch was masked
   output logic    fatal_o,                  // both copies bad on some port

   output logic [1:0] bank_we_o,             // per bank write enable
   output rf_add   bank_add_o,               // shared write address
   output rf_word  bank_val_o                // shared write data
);

   rf_entry    c0 [2];                       // copy 0 entry per port
   rf_entry    c1 [2];                       // copy 1 entry per port
   rf_add      ra [2];                       // read address per port
   rf_word     rd_val [2];                   // selected word per port

   logic [1:0] ok0;                          // copy 0 parity good
   logic [1:0] ok1;                          // copy 1 parity good
   logic [1:0] corr;                         // correction seen on port
   logic [1:0] fatal;                        // no good copy on port
   logic [1:0] cap;                          // record a new repair this cycle
   logic [1:0] cancel;                       // writeback hits pending address
   logic [1:0] rep_go;                       // slot owns the write port now

   repair_st   slot_st [2];                  // repair slot state per port
   rf_add      slot_add [2];                 // address to repair
   rf_word     slot_val [2];                 // good value to put back
   logic [1:0] slot_bank;                    // bank holding the bad copy

   // gather the four entries by port so both ports share the same logic
   assign c0[0] = b0_q1_i;
   assign c0[1] = b0_q2_i;
   assign c1[0] = b1_q1_i;
   assign c1[1] = b1_q2_i;
   assign ra[0] = rd1_add_i;
   assign ra[1] = rd2_add_i;

   // parity check, selection and flags
   always_comb begin
      for (int p = 0; p < 2; p++) begin
         ok0[p]    = ~^c0[p];                // even parity holds
         ok1[p]    = ~^c1[p];
         if (ok0[p]) begin
            rd_val[p] = c0[p][XLEN-1:0];     // copy 0 preferred
         end else if (ok1[p]) begin
            rd_val[p] = c1[p][XLEN-1:0];     // fall back to copy 1
         end else begin
            rd_val[p] = c0[p][XLEN-1:0];     // nothing good so copy 0 passes on
         end
         fatal[p]  = ~ok0[p] & ~ok1[p];
         corr[p]   = (ra[p] != '0) && (c0[p] != c1[p]) && (ok0[p] || ok1[p]);
         cancel[p] = wb_we_i && (wb_add_i == slot_add[p]);
         // a writeback to the same address makes the good value stale
         cap[p]    = corr[p] && acm_en_i && (slot_st[p] == RP_IDLE)
                     && !(wb_we_i && wb_add_i == ra[p]);
      end
   end

   assign rd1_val_o = rd_val[0];
   assign rd2_val_o = rd_val[1];
   assign corr_o    = |corr;
   assign fatal_o   = |fatal;

   // write port arbiter puts writeback first, then the port 1 slot, then port 2
   always_comb begin
      bank_we_o  = 2'b00;
      bank_add_o = wb_add_i;
      bank_val_o = wb_val_i;
      rep_go     = 2'b00;
      if (wb_we_i) begin
         bank_we_o = (wb_add_i != '0) ? 2'b11 : 2'b00;   // x0 writes dropped
      end else if (slot_st[0] == RP_PEND) begin
         bank_we_o[slot_bank[0]] = 1'b1;     // only the corrupted copy
         bank_add_o = slot_add[0];
         bank_val_o = slot_val[0];
         rep_go[0]  = 1'b1;
      end else if (slot_st[1] == RP_PEND) begin
         bank_we_o[slot_bank[1]] = 1'b1;
         bank_add_o = slot_add[1];
         bank_val_o = slot_val[1];
         rep_go[1]  = 1'b1;
      end
   end

   // slot state
   always_ff @(posedge s_clk_i) begin
      for (int p = 0; p < 2; p++) begin
         if (rst_i) begin
            slot_st[p] <= RP_IDLE;
         end else if (slot_st[p] == RP_PEND) begin
            if (rep_go[p] || cancel[p]) begin
               slot_st[p] <= RP_IDLE;        // done or overwritten
            end
         end else if (cap[p]) begin
            slot_st[p] <= RP_PEND;
         end
      end
   end

   // slot payload is only meaningful while pending
   always_ff @(posedge s_clk_i) begin
      for (int p = 0; p < 2; p++) begin
         if (cap[p]) begin
            slot_add[p]  <= ra[p];
            slot_val[p]  <= rd_val[p];
            slot_bank[p] <= ok0[p];          // copy 0 good means copy 1 is bad
         end
      end
   end

   // a repair cycle writes one copy only
   a_rep_onehot: assert property (
      @(posedge s_clk_i) disable iff (rst_i)
      (!wb_we_i && (slot_st[0] == RP_PEND || slot_st[1] == RP_PEND)) |-> $onehot(bank_we_o)
   );

   // x0 is never scheduled for repair
   a_slot_nz: assert property (
      @(posedge s_clk_i) disable iff (rst_i)
      (slot_st[0] != RP_PEND || slot_add[0] != '0)
      && (slot_st[1] != RP_PEND || slot_add[1] != '0)
   );

endmodule

// ==== hdl/rf_controller.sv ====
`timescale 1ns/1ps

module rf_controller
   import rf_pkg::*;
(
   input  logic   s_clk_i,                   // clock shared by both copies
   input  logic   rst_i,                     // sync reset, active high

   input  logic   wb_we_i,                   // writeback enable
   input  rf_add  wb_add_i,                  // writeback destination
   input  rf_word wb_val_i,                  // writeback result

   input  rf_add  rd1_add_i,                 // read port 1 address
   input  rf_add  rd2_add_i,                 // read port 2 address

   input  logic   acm_en_i,                  // repair enable setting

   input  logic   inj_en_i,                  // fault injection strobe
   input  logic   inj_bank_i,                // copy to corrupt
   input  rf_add  inj_add_i,                 // register to corrupt
   input  bit_sel inj_bit_i,                 // bit to flip

   output rf_word rd1_val_o,                 // read port 1 value
   output rf_word rd2_val_o,                 // read port 2 value
   output logic   corr_o,                    // masked mismatch
   output logic   fatal_o                    // uncorrectable read
);

   logic [1:0] bank_we;                      // per copy write enable from acm
   rf_add      bank_add;                     // shared write address
   rf_word     bank_val;                     // shared write data
   rf_entry    b0_q1, b0_q2;                 // copy 0 read entries
   rf_entry    b1_q1, b1_q2;                 // copy 1 read entries
   logic       inj0_en, inj1_en;             // injection steered to one copy

   assign inj0_en = inj_en_i & ~inj_bank_i;
   assign inj1_en = inj_en_i & inj_bank_i;

   rf_acm m_acm (
      .s_clk_i   (s_clk_i),
      .rst_i     (rst_i),
      .wb_we_i   (wb_we_i),
      .wb_add_i  (wb_add_i),
      .wb_val_i  (wb_val_i),
      .rd1_add_i (rd1_add_i),
      .rd2_add_i (rd2_add_i),
      .acm_en_i  (acm_en_i),
      .b0_q1_i   (b0_q1),
      .b0_q2_i   (b0_q2),
      .b1_q1_i   (b1_q1),
      .b1_q2_i   (b1_q2),
      .rd1_val_o (rd1_val_o),
      .rd2_val_o (rd2_val_o),
      .corr_o    (corr_o),
      .fatal_o   (fatal_o),
      .bank_we_o (bank_we),
      .bank_add_o(bank_add),
      .bank_val_o(bank_val)
   );

   rf_bank m_rf0_gpr (                       // copy 0
      .s_clk_i  (s_clk_i),
      .rst_i    (rst_i),
      .we_i     (bank_we[0]),
      .wa_i     (bank_add),
      .d_i      (bank_val),
      .ra1_i    (rd1_add_i),
      .ra2_i    (rd2_add_i),
      .inj_en_i (inj0_en),
      .inj_add_i(inj_add_i),
      .inj_bit_i(inj_bit_i),
      .q1_o     (b0_q1),
      .q2_o     (b0_q2)
   );

   rf_bank m_rf1_gpr (                       // copy 1
      .s_clk_i  (s_clk_i),
      .rst_i    (rst_i),
      .we_i     (bank_we[1]),
      .wa_i     (bank_add),
      .d_i      (bank_val),
      .ra1_i    (rd1_add_i),
      .ra2_i    (rd2_add_i),
      .inj_en_i (inj1_en),
      .inj_add_i(inj_add_i),
      .inj_bit_i(inj_bit_i),
      .q1_o     (b1_q1),
      .q2_o     (b1_q2)
   );

endmodule

// ==== tests/rf_checker.sv ====
`timescale 1ns/1ps

module rf_checker
   import rf_pkg::*;
(
   input  logic         s_clk_i,             // tb clock
   input  logic         rst_i,               // sync reset, active high
   input  logic         wb_we_i,             // watched writeback enable
   input  rf_add        wb_add_i,            // watched writeback address
   input  rf_word       wb_val_i,            // watched writeback data
   input  rf_add        rd1_add_i,           // port 1 address driven to the DUT
   input  rf_add        rd2_add_i,           // port 2 address driven to the DUT
   input  rf_word       rd1_val_i,           // DUT port 1 result
   input  rf_word       rd2_val_i,           // DUT port 2 result
   input  logic         corr_i,              // DUT correction flag
   input  logic         fatal_i,             // DUT uncorrectable flag
   input  logic         chk_en_i,            // this cycle is a read check
   input  logic [127:0] name_i,              // row name, ascii
   input  rf_word       mask_i,              // bits expected flipped in the result
   input  logic         exp_corr_i,          // expected corr_o
   input  logic         exp_fatal_i,         // expected fatal_o
   output int           n_chk_o,             // checks done
   output int           n_err_o              // checks that failed
);

   rf_word model [NREG];                     // reference register contents
   rf_word exp1;                             // expected port 1 word
   rf_word exp2;                             // expected port 2 word
   string  msg;                              // mismatches of the current check
   int     n_chk = 0;
   int     n_err = 0;

   // x0 never takes a write, so it stays at its reset value
   always @(posedge s_clk_i) begin
      if (rst_i) begin
         for (int i = 0; i < NREG; i++) begin
            model[i] <= '0;
         end
      end else if (wb_we_i && wb_add_i != '0) begin
         model[wb_add_i] <= wb_val_i;        // visible one edge later
      end
   end

   // inputs move on the rising edge, so compare on the falling one
   always @(negedge s_clk_i) begin
      if (chk_en_i) begin
         msg  = "";
         exp1 = model[rd1_add_i] ^ mask_i;
         exp2 = model[rd2_add_i] ^ mask_i;
         if (rd1_val_i !== exp1) begin
            msg = {msg, $sformatf(" rd1 expected %h actual %h", exp1, rd1_val_i)};
         end
         if (rd2_val_i !== exp2) begin
            msg = {msg, $sformatf(" rd2 expected %h actual %h", exp2, rd2_val_i)};
         end
         if (corr_i !== exp_corr_i) begin
            msg = {msg, $sformatf(" corr expected %b actual %b", exp_corr_i, corr_i)};
         end
         if (fatal_i !== exp_fatal_i) begin
            msg = {msg, $sformatf(" fatal expected %b actual %b", exp_fatal_i, fatal_i)};
         end
         n_chk = n_chk + 1;
         if (msg == "") begin
            $display("ok    %0s", name_i);
         end else begin
            $display("error %0s:%s", name_i, msg);
            n_err = n_err + 1;
         end
      end
   end

   assign n_chk_o = n_chk;
   assign n_err_o = n_err;

endmodule

// ==== tests/tb_rf_controller.sv ====
`timescale 1ns/1ps

module tb_rf_controller
   import rf_pkg::*;
();

   typedef enum logic [1:0] {OP_IDLE, OP_WR, OP_INJ, OP_RD} op_t;   // kind of table row

   logic         clk;
   logic         rst;
   logic         wb_we;
   rf_add        wb_add;
   rf_word       wb_val;
   rf_add        rd1_add;
   rf_add        rd2_add;
   logic         acm_en;
   logic         inj_en;
   logic         inj_bank;
   rf_add        inj_add;
   bit_sel       inj_bit;
   rf_word       rd1_val;
   rf_word       rd2_val;
   logic         corr;
   logic         fatal;

   logic         chk_en;                     // tells the checker a read is up
   logic [127:0] chk_name;
   rf_word       chk_mask;
   logic         exp_corr;
   logic         exp_fatal;
   int           n_chk;
   int           n_err;

   // stimulus table, one row per clock cycle
   logic [127:0] t_name [$];
   op_t          t_op [$];
   rf_add        t_a1 [$];                   // write, inject or port 1 address
   rf_add        t_a2 [$];                   // port 2 address
   rf_word       t_val [$];
   logic         t_bank [$];
   bit_sel       t_bit [$];
   logic         t_acm [$];
   rf_word       t_mask [$];                 // read rows only
   logic         t_corr [$];
   logic         t_fatal [$];

   logic [31:0]  lfsr_q = 32'hda19_f3de;     // x^32 + x^22 + x^2 + x + 1
   int           n_reads = 0;
   int           limit = 0;                  // timeout in cycles
   int           cyc;

   rf_controller dut (
      .s_clk_i   (clk),
      .rst_i     (rst),
      .wb_we_i   (wb_we),
      .wb_add_i  (wb_add),
      .wb_val_i  (wb_val),
      .rd1_add_i (rd1_add),
      .rd2_add_i (rd2_add),
      .acm_en_i  (acm_en),
      .inj_en_i  (inj_en),
      .inj_bank_i(inj_bank),
      .inj_add_i (inj_add),
      .inj_bit_i (inj_bit),
      .rd1_val_o (rd1_val),
      .rd2_val_o (rd2_val),
      .corr_o    (corr),
      .fatal_o   (fatal)
   );

   rf_checker chk (
      .s_clk_i    (clk),
      .rst_i      (rst),
      .wb_we_i    (wb_we),
      .wb_add_i   (wb_add),
      .wb_val_i   (wb_val),
      .rd1_add_i  (rd1_add),
      .rd2_add_i  (rd2_add),
      .rd1_val_i  (rd1_val),
      .rd2_val_i  (rd2_val),
      .corr_i     (corr),
      .fatal_i    (fatal),
      .chk_en_i   (chk_en),
      .name_i     (chk_name),
      .mask_i     (chk_mask),
      .exp_corr_i (exp_corr),
      .exp_fatal_i(exp_fatal),
      .n_chk_o    (n_chk),
      .n_err_o    (n_err)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;                 // 8 ns period
   end

   // one lfsr step, the new bit is the one handed out
   function automatic logic next_rand_bit();
      logic fb;
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      return fb;
   endfunction

   function automatic rf_word rand_word();
      rf_word w;
      w = '0;
      for (int i = 0; i < XLEN; i++) begin
         w = {w[XLEN-2:0], next_rand_bit()};
      end
      return w;
   endfunction

   task automatic store_row(input logic [127:0] nm, input op_t op, input rf_add a1,
                            input rf_add a2, input rf_word val, input logic bank,
                            input bit_sel bn, input logic acm, input rf_word mask,
                            input logic ec, input logic ef);
      t_name.push_back(nm);
      t_op.push_back(op);
      t_a1.push_back(a1);
      t_a2.push_back(a2);
      t_val.push_back(val);
      t_bank.push_back(bank);
      t_bit.push_back(bn);
      t_acm.push_back(acm);
      t_mask.push_back(mask);
      t_corr.push_back(ec);
      t_fatal.push_back(ef);
   endtask

   task automatic write_row(input logic [127:0] nm, input rf_add a, input rf_word val);
      store_row(nm, OP_WR, a, '0, val, 1'b0, '0, 1'b0, '0, 1'b0, 1'b0);
   endtask

   task automatic inject_row(input logic [127:0] nm, input logic bank, input rf_add a,
                             input bit_sel bn, input logic acm);
      store_row(nm, OP_INJ, a, '0, '0, bank, bn, acm, '0, 1'b0, 1'b0);
   endtask

   task automatic read_row(input logic [127:0] nm, input rf_add a1, input rf_add a2,
                           input logic acm, input logic ec, input logic ef,
                           input rf_word mask);
      store_row(nm, OP_RD, a1, a2, '0, 1'b0, '0, acm, mask, ec, ef);
      n_reads = n_reads + 1;
   endtask

   task automatic idle_row(input logic acm);
      store_row("idle", OP_IDLE, '0, '0, '0, 1'b0, '0, acm, '0, 1'b0, 1'b0);
   endtask

   task automatic build_table();
      for (int r = 1; r <= 10; r++) begin
         write_row("wr_rand", rf_add'(r), rand_word());
      end
      write_row("wr_rand", 5'd31, rand_word());
      read_row("rd_r1_r2", 5'd1, 5'd2, 1'b0, 1'b0, 1'b0, '0);
      read_row("rd_r3_r4", 5'd3, 5'd4, 1'b0, 1'b0, 1'b0, '0);
      read_row("rd_r5_r6", 5'd5, 5'd6, 1'b0, 1'b0, 1'b0, '0);
      read_row("rd_r7_r8", 5'd7, 5'd8, 1'b0, 1'b0, 1'b0, '0);
      read_row("rd_r9_r10", 5'd9, 5'd10, 1'b0, 1'b0, 1'b0, '0);
      read_row("rd_r31_r1", 5'd31, 5'd1, 1'b0, 1'b0, 1'b0, '0);
      write_row("wr_r0", 5'd0, rand_word());                  // must be dropped
      read_row("rd_r0_r0", 5'd0, 5'd0, 1'b0, 1'b0, 1'b0, '0);
      read_row("rd_r0_r5", 5'd0, 5'd5, 1'b0, 1'b0, 1'b0, '0);
      // single upset with repair on: both ports book a repair
      write_row("wr_r12", 5'd12, rand_word());
      inject_row("inj_r12_b1", 1'b1, 5'd12, 6'd3, 1'b1);
      read_row("rd_r12_flip", 5'd12, 5'd12, 1'b1, 1'b1, 1'b0, '0);
      idle_row(1'b1);
      idle_row(1'b1);
      idle_row(1'b1);
      read_row("rd_r12_fixed", 5'd12, 5'd12, 1'b1, 1'b0, 1'b0, '0);
      // parity bit upset with repair off stays visible
      write_row("wr_r13", 5'd13, rand_word());
      inject_row("inj_r13_b0", 1'b0, 5'd13, 6'd32, 1'b0);
      read_row("rd_r13_noacm", 5'd13, 5'd13, 1'b0, 1'b1, 1'b0, '0);
      idle_row(1'b0);
      idle_row(1'b0);
      idle_row(1'b0);
      read_row("rd_r13_again", 5'd13, 5'd13, 1'b0, 1'b1, 1'b0, '0);
      // same bit in both copies, copy 0 word passes through
      write_row("wr_r14", 5'd14, rand_word());
      inject_row("inj_r14_b0", 1'b0, 5'd14, 6'd10, 1'b0);
      inject_row("inj_r14_b1", 1'b1, 5'd14, 6'd10, 1'b0);
      read_row("rd_r14_fatal", 5'd14, 5'd14, 1'b0, 1'b0, 1'b1, 32'h0000_0400);
      write_row("wr_r14_new", 5'd14, rand_word());
      read_row("rd_r14_new", 5'd14, 5'd14, 1'b0, 1'b0, 1'b0, '0);
      // booked repair dropped by a writeback to the same register
      write_row("wr_r15", 5'd15, rand_word());
      inject_row("inj_r15_b1", 1'b1, 5'd15, 6'd0, 1'b1);
      read_row("rd_r15_flip", 5'd15, 5'd15, 1'b1, 1'b1, 1'b0, '0);
      write_row("wr_r15_new", 5'd15, rand_word());
      idle_row(1'b1);
      read_row("rd_r15_cancel", 5'd15, 5'd15, 1'b1, 1'b0, 1'b0, '0);
      write_row("wr_r16", 5'd16, rand_word());
      inject_row("inj_r16_b0", 1'b0, 5'd16, 6'd5, 1'b1);
      write_row("wr_r16_new", 5'd16, rand_word());               // lands on the flipped entry
      read_row("rd_r16_new", 5'd16, 5'd16, 1'b1, 1'b0, 1'b0, '0);
   endtask

   initial begin
      rst       = 1'b1;
      wb_we     = 1'b0;
      wb_add    = '0;
      wb_val    = '0;
      rd1_add   = '0;
      rd2_add   = '0;
      acm_en    = 1'b0;
      inj_en    = 1'b0;
      inj_bank  = 1'b0;
      inj_add   = '0;
      inj_bit   = '0;
      chk_en    = 1'b0;
      chk_name  = '0;
      chk_mask  = '0;
      exp_corr  = 1'b0;
      exp_fatal = 1'b0;
      build_table();
      limit = t_op.size() * 4 + 20;
      repeat (2) @(posedge clk);
      rst <= 1'b0;
      for (int i = 0; i < t_op.size(); i++) begin
         @(posedge clk);
         wb_we     <= (t_op[i] == OP_WR);
         wb_add    <= t_a1[i];
         wb_val    <= t_val[i];
         rd1_add   <= (t_op[i] == OP_RD) ? t_a1[i] : '0;   // non-read rows park at x0
         rd2_add   <= (t_op[i] == OP_RD) ? t_a2[i] : '0;
         acm_en    <= t_acm[i];
         inj_en    <= (t_op[i] == OP_INJ);
         inj_bank  <= t_bank[i];
         inj_add   <= t_a1[i];
         inj_bit   <= t_bit[i];
         chk_en    <= (t_op[i] == OP_RD);
         chk_name  <= t_name[i];
         chk_mask  <= t_mask[i];
         exp_corr  <= t_corr[i];
         exp_fatal <= t_fatal[i];
      end
      @(posedge clk);
      wb_we  <= 1'b0;
      inj_en <= 1'b0;
      chk_en <= 1'b0;
      @(posedge clk);                        // last check ran on the falling edge
      $display("checks %0d of %0d, errors %0d", n_chk, n_reads, n_err);
      if (n_err == 0 && n_chk == n_reads) begin
         $display("All tests passed");
      end else begin
         if (n_chk != n_reads) begin
            $display("not every read row of the table was checked");
         end
         $display("Some tests failed");
      end
      $finish;
   end

   // watchdog, sized from the table once it is built
   initial begin
      cyc = 0;
      wait (limit != 0);
      while (cyc < limit) begin
         @(posedge clk);
         cyc = cyc + 1;
      end
      $display("timeout after %0d cycles, the stimulus table did not finish", cyc);
      $display("Some tests failed");
      $finish;
   end

endmodule

// ==== tb.f ====
hdl/rf_pkg.sv
hdl/rf_bank.sv
hdl/rf_acm.sv
hdl/rf_controller.sv
tests/rf_checker.sv
tests/tb_rf_controller.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_rf_controller
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= Some tests failed
PASS_MSG  ?= All tests passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build $(TOP) with verilator, run it, search $(LOG) for the fail message"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "FAIL"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "FAIL: run ended without a result line"; exit 1; \
	else \
		echo "PASS"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
